/* hdl/gb_bus_pkg.sv */
// system bus glue for the handheld console core
// shared widths, request and select structs, register map and irq vectors

package gb_bus_pkg;

	// ------------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------------
	typedef logic [15:0] addr_t;     // cpu address
	typedef logic [7:0]  data_t;     // bus byte
	typedef logic [4:0]  irq_mask_t; // vblank, lcd, timer, serial, joypad
	typedef logic [2:0]  bank_t;     // wram bank 0..7

	// cpu side request, held by the cpu for the whole access
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;    // level
		logic  wr;    // level, acted on at its rising edge
	} cpu_req_t;

	// one-hot decode of the current address
	typedef struct packed {
		logic sel_wram;  // c000-fdff incl. echo
		logic sel_zpram; // ff80-fffe
		logic sel_if;
		logic sel_ie;
		logic sel_joy;
		logic sel_key1;  // cgb only
		logic sel_svbk;  // cgb only
		logic sel_ff72;
		logic sel_ff73;
		logic sel_ff74;
		logic sel_ff75;
	} bus_sel_t;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------
	localparam addr_t ADDR_JOY  = 16'hff00;
	localparam addr_t ADDR_IF   = 16'hff0f;
	localparam addr_t ADDR_KEY1 = 16'hff4d; // speed switch
	localparam addr_t ADDR_SVBK = 16'hff70; // wram bank
	localparam addr_t ADDR_FF72 = 16'hff72;
	localparam addr_t ADDR_FF73 = 16'hff73;
	localparam addr_t ADDR_FF74 = 16'hff74;
	localparam addr_t ADDR_FF75 = 16'hff75;
	localparam addr_t ADDR_IE   = 16'hffff;

	// rst vectors 40h, 48h, .. 60h, one step per flag
	localparam data_t VEC_BASE = 8'h40;
	localparam data_t VEC_STEP = 8'h08;

	localparam data_t OPEN_BUS = 8'hff; // nothing drives the bus

endpackage

/* hdl/gb_bus_decode.sv */
// cpu bus address decode
// one-hot selects plus write strobe and end-of-acknowledge pulse

`timescale 1ns/100ps

module gb_bus_decode (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::cpu_req_t  cpu_req,
	input  logic                  irq_ack,
	input  logic                  is_gbc,
	output gb_bus_pkg::bus_sel_t  sel,
	output logic                  wr_stb,
	output logic                  ack_end
);

	gb_bus_pkg::addr_t a;
	logic              wr_d;  // previous wr level
	logic              ack_d; // previous ack level

	assign a = cpu_req.addr;

	// ------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------
	always_comb begin
		sel = '0;
		// c000-dfff, echo e000-fdff, fe00 and up excluded
		sel.sel_wram  = (a[15:14] == 2'b11) && !(&a[13:9]);
		sel.sel_zpram = (a[15:7] == 9'h1ff) && (a != gb_bus_pkg::ADDR_IE);
		sel.sel_if    = (a == gb_bus_pkg::ADDR_IF);
		sel.sel_ie    = (a == gb_bus_pkg::ADDR_IE);
		sel.sel_joy   = (a == gb_bus_pkg::ADDR_JOY);

		// cgb only registers, dmg sees open bus
		sel.sel_key1  = is_gbc && (a == gb_bus_pkg::ADDR_KEY1);
		sel.sel_svbk  = is_gbc && (a == gb_bus_pkg::ADDR_SVBK);
		sel.sel_ff72  = is_gbc && (a == gb_bus_pkg::ADDR_FF72);
		sel.sel_ff73  = is_gbc && (a == gb_bus_pkg::ADDR_FF73);
		sel.sel_ff74  = is_gbc && (a == gb_bus_pkg::ADDR_FF74);
		sel.sel_ff75  = is_gbc && (a == gb_bus_pkg::ADDR_FF75);
	end

	// ------------------------------------------------------------------
	// edge detection
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			wr_d    <= 1'b0;
			ack_d   <= 1'b0;
			wr_stb  <= 1'b0;
			ack_end <= 1'b0;
		end else begin
			wr_d    <= cpu_req.wr;
			ack_d   <= irq_ack;
			wr_stb  <= cpu_req.wr & ~wr_d; // one pulse per write access
			ack_end <= ack_d & ~irq_ack;   // ack just dropped
		end
	end

endmodule

/* hdl/gb_irq_ctrl.sv */
// interrupt controller, IF and IE registers
// source edge detect, joypad sync, vector priority and ack clearing

`timescale 1ns/100ps

module gb_irq_ctrl #(
	parameter int JOY_SYNC_STAGES = 2 // must be 2 or more
) (
	input  logic                    clk_sys,
	input  logic                    reset_ss,
	input  gb_bus_pkg::bus_sel_t    sel,
	input  logic                    wr_stb,
	input  gb_bus_pkg::data_t       wdata,
	input  logic                    ack_end,
	input  logic [3:0]              irq_src,   // vblank, lcd, timer, serial
	input  logic [3:0]              joy_din,
	output gb_bus_pkg::irq_mask_t   if_q,
	output gb_bus_pkg::data_t       ie_q,
	output gb_bus_pkg::data_t       vector,
	output logic                    irq_n
);

	logic [3:0]                         src_d;    // sources one cycle back
	logic [JOY_SYNC_STAGES-1:0][3:0]    joy_sync; // input synchronizer
	gb_bus_pkg::irq_mask_t              set_mask;
	gb_bus_pkg::irq_mask_t              pend;     // flagged and enabled
	gb_bus_pkg::irq_mask_t              clr_mask;
	logic                               joy_fall;

	// any of P10..P13 going low
	assign joy_fall = |(~joy_sync[JOY_SYNC_STAGES-2] & joy_sync[JOY_SYNC_STAGES-1]);
	assign set_mask = {joy_fall, irq_src & ~src_d};

	assign pend     = if_q & ie_q[4:0];
	assign irq_n    = ~|pend;
	// lowest set bit wins, that is the one the cpu is serving
	assign clr_mask = ack_end ? (pend & (~pend + 5'd1)) : 5'd0;

	// ------------------------------------------------------------------
	// vector priority, bit 0 highest
	// ------------------------------------------------------------------
	always_comb begin
		vector = 8'h00; // nothing pending
		for (int i = 4; i >= 0; i--) begin
			if (pend[i])
				vector = gb_bus_pkg::VEC_BASE +
					gb_bus_pkg::data_t'(i) * gb_bus_pkg::VEC_STEP;
		end
	end

	// ------------------------------------------------------------------
	// flag and enable registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			src_d    <= 4'h0;
			joy_sync <= '1; // lines idle high
			if_q     <= 5'h00;
			ie_q     <= 8'h00;
		end else begin
			src_d       <= irq_src;
			joy_sync[0] <= joy_din;
			for (int i = 1; i < JOY_SYNC_STAGES; i++)
				joy_sync[i] <= joy_sync[i-1];

			// ack clear beats a new edge on the same flag
			if_q <= (if_q | set_mask) & ~clr_mask;

			// direct cpu writes override everything above
			if (wr_stb && sel.sel_if)
				if_q <= wdata[4:0];
			if (wr_stb && sel.sel_ie)
				ie_q <= wdata;
		end
	end

endmodule

/* hdl/gb_sys_regs.sv */
// small system registers
// joypad select, KEY1 speed switch, SVBK bank and spare cgb regs

`timescale 1ns/100ps

module gb_sys_regs (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::bus_sel_t  sel,
	input  logic                  wr_stb,
	input  gb_bus_pkg::data_t     wdata,
	input  logic                  cpu_stop,  // stop instruction pulse
	output logic [1:0]            joy_p54,
	output logic                  speed,     // 1 = double speed
	output logic                  prepare,   // KEY1 bit 0
	output gb_bus_pkg::bank_t     wram_bank,
	output gb_bus_pkg::data_t     ff72_q,
	output gb_bus_pkg::data_t     ff73_q,
	output gb_bus_pkg::data_t     ff74_q,
	output logic [2:0]            ff75_q     // bits 6..4 only
);

	// ------------------------------------------------------------------
	// joypad select and speed switch
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_p54 <= 2'b00;
			speed   <= 1'b0;
			prepare <= 1'b0;
		end else begin
			if (wr_stb && sel.sel_joy)
				joy_p54 <= wdata[5:4]; // P15/P14 select lines
			if (wr_stb && sel.sel_key1)
				prepare <= wdata[0];

			// stop with prepare armed does the switch
			if (cpu_stop && prepare) begin
				speed   <= ~speed;
				prepare <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// wram bank
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			wram_bank <= 3'd1;
		else if (wr_stb && sel.sel_svbk) begin
			if (wdata[2:0] == 3'd0)
				wram_bank <= 3'd1; // bank 0 not mappable at d000
			else
				wram_bank <= wdata[2:0];
		end
	end

	// ------------------------------------------------------------------
	// spare cgb registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ff72_q <= 8'h00;
			ff73_q <= 8'h00;
			ff74_q <= 8'h00;
			ff75_q <= 3'd0;
		end else if (wr_stb) begin
			if (sel.sel_ff72) ff72_q <= wdata;
			if (sel.sel_ff73) ff73_q <= wdata;
			if (sel.sel_ff74) ff74_q <= wdata;
			if (sel.sel_ff75) ff75_q <= wdata[6:4];
		end
	end

endmodule

/* hdl/gb_wram.sv */
// banked 32k work ram and 127 byte high page ram
// single port, synchronous read

`timescale 1ns/100ps

module gb_wram (
	input  logic                  clk_sys,
	input  gb_bus_pkg::bus_sel_t  sel,
	input  logic                  wr_stb,
	input  gb_bus_pkg::addr_t     addr,
	input  gb_bus_pkg::data_t     wdata,
	input  gb_bus_pkg::bank_t     wram_bank,
	output gb_bus_pkg::data_t     wram_q,
	output gb_bus_pkg::data_t     zpram_q
);

	gb_bus_pkg::data_t wram_mem [0:32767]; // 8 x 4k
	gb_bus_pkg::data_t zpram_mem [0:127];  // ffff slot never written

	logic [14:0]       wram_addr;
	gb_bus_pkg::bank_t bank_sel;

	// c000-cfff always bank 0, d000-dfff the switched bank
	// echo area aliases through the same bits
	assign bank_sel  = addr[12] ? wram_bank : 3'd0;
	assign wram_addr = {bank_sel, addr[11:0]};

	// ------------------------------------------------------------------
	// work ram
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (wr_stb && sel.sel_wram)
			wram_mem[wram_addr] <= wdata;
		wram_q <= wram_mem[wram_addr];
	end

	// ------------------------------------------------------------------
	// high page ram
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (wr_stb && sel.sel_zpram)
			zpram_mem[addr[6:0]] <= wdata;
		zpram_q <= zpram_mem[addr[6:0]];
	end

endmodule

/* hdl/gb_read_mux.sv */
// cpu read data mux, registered so register and ram paths line up

`timescale 1ns/100ps

module gb_read_mux (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::bus_sel_t  sel,
	input  logic                  irq_ack,
	input  gb_bus_pkg::data_t     vector,
	input  gb_bus_pkg::irq_mask_t if_q,
	input  gb_bus_pkg::data_t     ie_q,
	input  logic [3:0]            joy_din,
	input  logic [1:0]            joy_p54,
	input  logic                  speed,
	input  logic                  prepare,
	input  gb_bus_pkg::bank_t     wram_bank,
	input  gb_bus_pkg::data_t     ff72_q,
	input  gb_bus_pkg::data_t     ff73_q,
	input  gb_bus_pkg::data_t     ff74_q,
	input  logic [2:0]            ff75_q,
	input  gb_bus_pkg::data_t     wram_q,   // already one cycle late
	input  gb_bus_pkg::data_t     zpram_q,
	output gb_bus_pkg::data_t     cpu_rdata
);

	gb_bus_pkg::data_t reg_c;
	gb_bus_pkg::data_t reg_q;
	logic              wram_sel_q; // select delayed to match ram latency
	logic              zpram_sel_q;

	always_comb begin
		if (irq_ack)            reg_c = vector; // ack beats any address
		else if (sel.sel_if)    reg_c = {3'b111, if_q};
		else if (sel.sel_svbk)  reg_c = {5'h1f, wram_bank};
		else if (sel.sel_key1)  reg_c = {speed, 6'h3f, prepare};
		else if (sel.sel_joy)   reg_c = {2'b11, joy_p54, joy_din};
		else if (sel.sel_ff72)  reg_c = ff72_q;
		else if (sel.sel_ff73)  reg_c = ff73_q;
		else if (sel.sel_ff74)  reg_c = ff74_q;
		else if (sel.sel_ff75)  reg_c = {1'b1, ff75_q, 4'hf};
		else if (sel.sel_ie)    reg_c = ie_q;
		else                    reg_c = gb_bus_pkg::OPEN_BUS;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			reg_q       <= gb_bus_pkg::OPEN_BUS;
			wram_sel_q  <= 1'b0;
			zpram_sel_q <= 1'b0;
		end else begin
			reg_q       <= reg_c;
			wram_sel_q  <= sel.sel_wram & ~irq_ack;
			zpram_sel_q <= sel.sel_zpram & ~irq_ack;
		end
	end

	assign cpu_rdata = wram_sel_q  ? wram_q :
	                   zpram_sel_q ? zpram_q : reg_q;

endmodule

/* hdl/gb_core_bus.sv */
// system bus glue top level
// decode in front, registers irq and rams in the middle, read mux out

`timescale 1ns/100ps

module gb_core_bus #(
	parameter int JOY_SYNC_STAGES = 2 // joypad input sync depth
) (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::cpu_req_t  cpu_req,
	input  logic                  irq_ack,
	input  logic                  is_gbc,
	input  logic [3:0]            irq_src,
	input  logic [3:0]            joy_din,
	input  logic                  cpu_stop,
	output gb_bus_pkg::data_t     cpu_rdata,
	output logic                  irq_n,
	output logic [1:0]            joy_p54,
	output logic                  speed
);

	gb_bus_pkg::bus_sel_t  sel;
	logic                  wr_stb;
	logic                  ack_end;
	gb_bus_pkg::irq_mask_t if_q;
	gb_bus_pkg::data_t     ie_q;
	gb_bus_pkg::data_t     vector;
	logic                  prepare;
	gb_bus_pkg::bank_t     wram_bank;
	gb_bus_pkg::data_t     ff72_q, ff73_q, ff74_q;
	logic [2:0]            ff75_q;
	gb_bus_pkg::data_t     wram_q, zpram_q;

	// ------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------
	gb_bus_decode u_decode (
		.clk_sys, .reset_ss, .cpu_req, .irq_ack, .is_gbc,
		.sel, .wr_stb, .ack_end
	);

	// ------------------------------------------------------------------
	// registers, interrupts and memories
	// ------------------------------------------------------------------
	gb_irq_ctrl #(.JOY_SYNC_STAGES(JOY_SYNC_STAGES)) u_irq (
		.clk_sys, .reset_ss, .sel, .wr_stb, .wdata(cpu_req.wdata), .ack_end,
		.irq_src, .joy_din, .if_q, .ie_q, .vector, .irq_n
	);

	gb_sys_regs u_regs (
		.clk_sys, .reset_ss, .sel, .wr_stb, .wdata(cpu_req.wdata), .cpu_stop,
		.joy_p54, .speed, .prepare, .wram_bank,
		.ff72_q, .ff73_q, .ff74_q, .ff75_q
	);

	gb_wram u_wram (
		.clk_sys, .sel, .wr_stb, .addr(cpu_req.addr), .wdata(cpu_req.wdata),
		.wram_bank, .wram_q, .zpram_q
	);

	// ------------------------------------------------------------------
	// output side
	// ------------------------------------------------------------------
	gb_read_mux u_mux (
		.clk_sys, .reset_ss, .sel, .irq_ack, .vector, .if_q, .ie_q,
		.joy_din, .joy_p54, .speed, .prepare, .wram_bank,
		.ff72_q, .ff73_q, .ff74_q, .ff75_q, .wram_q, .zpram_q,
		.cpu_rdata
	);

endmodule

/* tests/gb_bus_ref.svh */
// reference model for the bus glue testbench
// shadow of rams and registers, expected read bytes and irq vector
`ifndef GB_BUS_REF_SVH
`define GB_BUS_REF_SVH

// ----------------------------------------------------------------------
// shadow state
// ----------------------------------------------------------------------
gb_bus_pkg::data_t     wram_sh [0:32767];
bit                    wram_ok [0:32767]; // location written at least once
gb_bus_pkg::data_t     zp_sh [0:127];
gb_bus_pkg::irq_mask_t if_sh;
gb_bus_pkg::data_t     ie_sh;
logic [1:0]            p54_sh;
logic [3:0]            joy_sh;            // current joy_din level
logic                  speed_sh;
logic                  prep_sh;
gb_bus_pkg::bank_t     bank_sh;
gb_bus_pkg::data_t     ff72_sh, ff73_sh, ff74_sh;
logic [2:0]            ff75_sh;
logic                  gbc_sh;

// c000-cfff is bank 0, d000-dfff the switched bank, echo follows bit 12
function automatic int wram_index(input logic [15:0] a);
	return (a[12] ? int'(bank_sh) : 0) * 4096 + int'(a[11:0]);
endfunction

function automatic bit in_wram(input logic [15:0] a);
	return (a >= 16'hc000) && (a <= 16'hfdff);
endfunction

function automatic gb_bus_pkg::data_t ref_read(input logic [15:0] a);
	if (in_wram(a))                      return wram_sh[wram_index(a)];
	if (a >= 16'hff80 && a <= 16'hfffe) return zp_sh[a[6:0]];
	if (a == 16'hff0f)                  return {3'b111, if_sh};
	if (a == 16'hffff)                  return ie_sh;
	if (a == 16'hff00)                  return {2'b11, p54_sh, joy_sh};
	if (gbc_sh) begin
		if (a == 16'hff4d) return {speed_sh, 6'h3f, prep_sh};
		if (a == 16'hff70) return {5'h1f, bank_sh};
		if (a == 16'hff72) return ff72_sh;
		if (a == 16'hff73) return ff73_sh;
		if (a == 16'hff74) return ff74_sh;
		if (a == 16'hff75) return {1'b1, ff75_sh, 4'hf};
	end
	return 8'hff; // open bus
endfunction

// lowest enabled flag wins, vector 40h + 8 * n
function automatic gb_bus_pkg::data_t ref_vector(input logic [4:0] flags,
		input logic [7:0] enables);
	for (int n = 0; n < 5; n++)
		if (flags[n] && enables[n])
			return 8'h40 + 8'(n * 8);
	return 8'h00;
endfunction

`endif

/* tests/tb_gb_core_bus.sv */
// testbench for the system bus glue
// random ram traffic, register readback, interrupts and dmg mode

`timescale 1ns/100ps

module tb_gb_core_bus;

	localparam int LEN_WRAM = 48 * 40;
	localparam int LEN_ZP   = 40 * 12;
	localparam int LEN_REGS = 200;
	localparam int LEN_IRQ  = 24 * 40;
	localparam int LEN_JOY  = 4 * 30;
	localparam int LEN_DMG  = 150;
	localparam int LIMIT    = 2 * (LEN_WRAM + LEN_ZP + LEN_REGS + LEN_IRQ + LEN_JOY + LEN_DMG);

	logic                 clk_sys = 1'b0;
	logic                 reset_ss;
	gb_bus_pkg::cpu_req_t cpu_req;
	logic                 irq_ack, is_gbc, cpu_stop;
	logic [3:0]           irq_src, joy_din;
	gb_bus_pkg::data_t    cpu_rdata;
	logic                 irq_n, speed;
	logic [1:0]           joy_p54;

	int                   n_checks = 0;
	int                   n_errors = 0;
	int                   t_checks, t_errors; // counts at test start
	int                   cycles = 0;
	logic                 chk_valid = 1'b0;   // cpu_rdata due at next negedge
	gb_bus_pkg::data_t    chk_exp;
	logic [15:0]          chk_addr;

	`include "gb_bus_ref.svh"

	gb_core_bus #(.JOY_SYNC_STAGES(2)) DUT (
		.clk_sys, .reset_ss, .cpu_req, .irq_ack, .is_gbc, .irq_src, .joy_din,
		.cpu_stop, .cpu_rdata, .irq_n, .joy_p54, .speed
	);

	always #5 clk_sys = ~clk_sys;

	// ------------------------------------------------------------------
	// comparison process and watchdog
	// ------------------------------------------------------------------
	always @(negedge clk_sys) begin
		if (chk_valid) begin
			n_checks++;
			if (cpu_rdata !== chk_exp) begin
				n_errors++;
				$display("error at %0t: read %h got %h expected %h",
					$time, chk_addr, cpu_rdata, chk_exp);
			end
			chk_valid = 1'b0;
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("run stopped, cycle limit of %0d reached", LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// bus write, shadow follows once the strobe edge has passed
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cpu_req.addr  <= a;
		cpu_req.wdata <= d;
		cpu_req.wr    <= 1'b1;
		cpu_req.rd    <= 1'b0;
		repeat (2) @(posedge clk_sys);
		cpu_req.wr <= 1'b0;
		if (in_wram(a)) begin
			wram_sh[wram_index(a)] = d;
			wram_ok[wram_index(a)] = 1'b1;
		end else if (a >= 16'hff80 && a <= 16'hfffe) zp_sh[a[6:0]] = d;
		else if (a == 16'hff0f) if_sh = d[4:0];
		else if (a == 16'hffff) ie_sh = d;
		else if (a == 16'hff00) p54_sh = d[5:4];
		else if (gbc_sh) begin
			if (a == 16'hff4d) prep_sh = d[0];
			if (a == 16'hff70) bank_sh = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
			if (a == 16'hff72) ff72_sh = d;
			if (a == 16'hff73) ff73_sh = d;
			if (a == 16'hff74) ff74_sh = d;
			if (a == 16'hff75) ff75_sh = d[6:4];
		end
	endtask

	// one cycle latency, compared at the following negedge
	task automatic bus_read(input logic [15:0] a);
		@(posedge clk_sys);
		cpu_req.addr <= a;
		cpu_req.rd   <= 1'b1;
		@(posedge clk_sys);
		chk_addr  = a;
		chk_exp   = ref_read(a);
		chk_valid = 1'b1;
	endtask

	// acknowledge with a ram address on the bus
	task automatic ack_cycle(input logic [15:0] a);
		gb_bus_pkg::data_t vec;
		@(posedge clk_sys);
		cpu_req.addr <= a;
		irq_ack      <= 1'b1;
		@(posedge clk_sys);
		chk_addr  = a;
		chk_exp   = ref_vector(if_sh, ie_sh);
		chk_valid = 1'b1;
		@(posedge clk_sys);
		irq_ack <= 1'b0;
		repeat (3) @(posedge clk_sys); // ack_end then the clear
		// flag behind the served vector drops
		vec = ref_vector(if_sh, ie_sh);
		if (vec != 8'h00)
			if_sh[(vec - 8'h40) >> 3] = 1'b0;
	endtask

	task automatic start_test();
		t_checks = n_checks;
		t_errors = n_errors;
	endtask

	// next rising edge, so the last pending compare is done
	task automatic end_test(input string name);
		@(posedge clk_sys);
		$display("%s: %0d checks, %0d errors", name, n_checks - t_checks,
			n_errors - t_errors);
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		logic [15:0] a;
		logic [15:0] used [$];
		logic [3:0]  v;
		void'($urandom(32'hb0664e6d));
		cpu_req  = '0;
		irq_ack  = 1'b0;
		is_gbc   = 1'b1;
		irq_src  = 4'h0;
		joy_din  = 4'hf;
		cpu_stop = 1'b0;
		reset_ss = 1'b1;
		if_sh    = 0;
		ie_sh    = 0;
		p54_sh   = 0;
		joy_sh   = 4'hf;
		speed_sh = 0;
		prep_sh  = 0;
		bank_sh  = 1;
		ff72_sh  = 0;
		ff73_sh  = 0;
		ff74_sh  = 0;
		ff75_sh  = 0;
		gbc_sh   = 1;
		repeat (2) @(posedge clk_sys);
		reset_ss <= 1'b0;

		start_test(); // work ram and banking
		for (int i = 0; i < 48; i++) begin
			bus_write(16'hff70, 8'($urandom));
			bus_read(16'hff70);
			a = 16'hc000 + 16'($urandom % 16'h2000);
			bus_write(a, 8'($urandom));
			used.push_back(a);
			bus_read(a);
			if (a < 16'hde00) bus_read(a + 16'h2000); // echo
			a = used[$urandom % used.size()];
			if (wram_ok[wram_index(a)]) bus_read(a);
		end
		end_test("wram");

		start_test(); // high page and open bus
		for (int i = 0; i < 32; i++) begin
			a = 16'hff80 + 16'($urandom % 127);
			bus_write(a, 8'($urandom));
			bus_read(a);
		end
		bus_read(16'hff03);
		bus_read(16'hfe00);
		bus_read(16'hff50);
		end_test("hram");

		start_test(); // system registers
		bus_write(16'hff00, 8'h20);
		@(negedge clk_sys) check_val("joy_p54", {6'd0, joy_p54}, {6'd0, p54_sh});
		@(posedge clk_sys) joy_din <= 4'ha;
		joy_sh = 4'ha;
		bus_read(16'hff00);
		@(posedge clk_sys) joy_din <= 4'hf;
		joy_sh = 4'hf;
		repeat (4) @(posedge clk_sys); // joypad flag from the falling lines
		if_sh[4] = 1'b1;
		for (int r = 16'hff72; r <= 16'hff75; r++) begin
			bus_write(16'(r), 8'($urandom));
			bus_read(16'(r));
		end
		bus_write(16'hff4d, 8'h01);
		bus_read(16'hff4d);
		@(posedge clk_sys) cpu_stop <= 1'b1;
		@(posedge clk_sys) cpu_stop <= 1'b0;
		speed_sh = ~speed_sh;
		prep_sh  = 1'b0;
		@(negedge clk_sys) check_val("speed", {7'd0, speed}, {7'd0, speed_sh});
		bus_read(16'hff4d);
		end_test("sysregs");

		start_test(); // interrupt set, priority and ack
		bus_write(16'hff0f, 8'h00);
		for (int i = 0; i < 24; i++) begin
			bus_write(16'hffff, 8'($urandom));
			bus_read(16'hffff);
			v = 4'($urandom);
			@(posedge clk_sys) irq_src <= v;
			@(posedge clk_sys) irq_src <= 4'h0;
			if_sh[3:0] = if_sh[3:0] | v;
			bus_read(16'hff0f);
			@(negedge clk_sys) check_val("irq_n", {7'd0, irq_n},
				{7'd0, ref_vector(if_sh, ie_sh) == 8'h00});
			ack_cycle(i[0] ? 16'hff80 : 16'hc000);
			bus_read(16'hff0f);
		end
		end_test("irq");

		start_test(); // joypad interrupt and direct IF write
		for (int i = 0; i < 4; i++) begin
			bus_write(16'hff0f, 8'h00);
			@(posedge clk_sys) joy_din <= ~(4'h1 << i);
			joy_sh = ~(4'h1 << i);
			repeat (2) @(posedge clk_sys); // read samples IF 3 cycles on
			if_sh[4] = 1'b1;
			bus_read(16'hff0f);
			@(posedge clk_sys) joy_din <= 4'hf;
			joy_sh = 4'hf;
			repeat (3) @(posedge clk_sys);
			bus_write(16'hff0f, 8'($urandom));
			bus_read(16'hff0f);
		end
		end_test("joypad");

		start_test(); // dmg mode
		bus_write(16'hff70, 8'h00); // back to bank 1
		bus_read(16'hff70);
		@(posedge clk_sys) is_gbc <= 1'b0;
		gbc_sh = 1'b0;
		for (int r = 16'hff72; r <= 16'hff75; r++) begin
			bus_write(16'(r), 8'h5a);
			bus_read(16'(r));
		end
		bus_write(16'hff4d, 8'h01);
		bus_read(16'hff4d);
		bus_write(16'hd123, 8'h3c); // lands in bank 1
		bus_write(16'hff70, 8'h05);
		bus_read(16'hff70);
		bus_read(16'hd123);
		bus_read(16'hf123);
		// cgb view again, dmg writes must have left no trace
		@(posedge clk_sys) is_gbc <= 1'b1;
		gbc_sh = 1'b1;
		for (int r = 16'hff72; r <= 16'hff75; r++)
			bus_read(16'(r));
		bus_read(16'hff4d);
		bus_read(16'hff70);
		end_test("dmg");

		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+tests
hdl/gb_bus_pkg.sv
hdl/gb_bus_decode.sv
hdl/gb_irq_ctrl.sv
hdl/gb_sys_regs.sv
hdl/gb_wram.sv
hdl/gb_read_mux.sv
hdl/gb_core_bus.sv
tests/tb_gb_core_bus.sv
